// ==== fpu_cmp_top.f ====
+incdir+hdl
hdl/fpu_float_pkg.sv
hdl/fpu_cmp_pkg.sv
hdl/fpu_fcmp.sv
hdl/fpu_class.sv
hdl/fpu_cmp_result.sv
hdl/fpu_cmp_top.sv
verification/fpu_cmp_tb.sv

// ==== hdl/fpu_cfg.svh ====
`ifndef FPU_CFG_SVH
`define FPU_CFG_SVH

// ------------------------------------------------------------
// binary32 field layout
// ------------------------------------------------------------
`define FPU_WORD_W	32
`define FPU_EXP_W	8
`define FPU_FRACT_W	23
`define FPU_SIGN_POS	31
`define FPU_EXP_MSB	30
`define FPU_EXP_LSB	23
`define FPU_QNAN_POS	22	// Top fraction bit is set for a quiet NaN.

// ------------------------------------------------------------
// Compare opcodes
// ------------------------------------------------------------
`define FPU_CMP_OP_W	3
`define FPU_CMP_EQ	3'd0
`define FPU_CMP_NE	3'd1
`define FPU_CMP_LT	3'd2
`define FPU_CMP_LE	3'd3
`define FPU_CMP_GT	3'd4
`define FPU_CMP_GE	3'd5	// Codes 6 and 7 are reserved.

// Bit positions of the one-hot operand class.
`define FPU_CLASS_W	10
`define FPU_CLASS_NINF	0
`define FPU_CLASS_NNORM	1
`define FPU_CLASS_NSUB	2
`define FPU_CLASS_NZERO	3
`define FPU_CLASS_PZERO	4
`define FPU_CLASS_PSUB	5
`define FPU_CLASS_PNORM	6
`define FPU_CLASS_PINF	7
`define FPU_CLASS_SNAN	8
`define FPU_CLASS_QNAN	9

`endif

// ==== hdl/fpu_class.sv ====
`timescale 1ns/100ps
`include "fpu_cfg.svh"

module fpu_class import fpu_float_pkg::*, fpu_cmp_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      start,
	input  float32_t  op,
	output fp_class_t op_class
);

	logic      sign;
	exp_t      exp;
	fract_t    fract;
	logic      exp_ff;
	logic      exp_00;
	logic      fract_00;
	fp_class_t class_d;

	assign sign     = op[`FPU_SIGN_POS];
	assign exp      = op[`FPU_EXP_MSB:`FPU_EXP_LSB];
	assign fract    = op[`FPU_FRACT_W-1:0];
	assign exp_ff   = &exp;
	assign exp_00   = ~(|exp);
	assign fract_00 = ~(|fract);

	always_comb begin
		class_d = '0;
		if (exp_ff && !fract_00) begin
			if (fract[`FPU_QNAN_POS]) begin
				class_d[`FPU_CLASS_QNAN] = 1'b1;
			end else begin
				class_d[`FPU_CLASS_SNAN] = 1'b1;	// NaN class ignores the sign.
			end
		end else if (exp_ff) begin
			class_d[sign ? `FPU_CLASS_NINF : `FPU_CLASS_PINF] = 1'b1;
		end else if (exp_00 && fract_00) begin
			class_d[sign ? `FPU_CLASS_NZERO : `FPU_CLASS_PZERO] = 1'b1;
		end else if (exp_00) begin
			class_d[sign ? `FPU_CLASS_NSUB : `FPU_CLASS_PSUB] = 1'b1;
		end else begin
			class_d[sign ? `FPU_CLASS_NNORM : `FPU_CLASS_PNORM] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			op_class <= '0;
		end else if (start) begin
			op_class <= class_d;	// Held until the next start.
		end
	end

endmodule

// ==== hdl/fpu_cmp_pkg.sv ====
`include "fpu_cfg.svh"

// Types that describe the compare operation itself.
package fpu_cmp_pkg;

	// Compare opcode that takes the FPU_CMP_* codes.
	typedef logic [`FPU_CMP_OP_W-1:0] cmp_op_t;

	// One-hot class indexed by the FPU_CLASS_* bit positions.
	typedef logic [`FPU_CLASS_W-1:0] fp_class_t;

endpackage

// ==== hdl/fpu_cmp_result.sv ====
`timescale 1ns/100ps
`include "fpu_cfg.svh"

module fpu_cmp_result import fpu_float_pkg::*, fpu_cmp_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      start,
	input  cmp_op_t   cmp_op,
	input  logic      altb,
	input  logic      blta,
	input  logic      aeqb,
	input  logic      unordered,
	input  logic      cmp_valid,
	input  fp_class_t class_a_q,
	input  fp_class_t class_b_q,
	output logic      done,
	output logic      flag,
	output logic      invalid,
	output fp_class_t class_a
);

	cmp_op_t op_q;
	logic    flag_d;
	logic    valid_op;
	logic    ordered_op;
	logic    snan_any;
	logic    invalid_d;

	// Opcode lines up with the stage 1 results.
	always_ff @(posedge clk) begin
		if (start) begin
			op_q <= cmp_op;
		end
	end

	// ------------------------------------------------------------
	// Flag select and exception
	// ------------------------------------------------------------
	always_comb begin
		valid_op   = 1'b1;
		ordered_op = 1'b0;
		case (op_q)
			`FPU_CMP_EQ: flag_d = aeqb;
			`FPU_CMP_NE: flag_d = ~aeqb;	// True for an unordered pair.
			`FPU_CMP_LT: begin
				flag_d     = altb;
				ordered_op = 1'b1;
			end
			`FPU_CMP_LE: begin
				flag_d     = altb | aeqb;
				ordered_op = 1'b1;
			end
			`FPU_CMP_GT: begin
				flag_d     = blta;
				ordered_op = 1'b1;
			end
			`FPU_CMP_GE: begin
				flag_d     = blta | aeqb;
				ordered_op = 1'b1;
			end
			default: begin
				flag_d   = 1'b0;
				valid_op = 1'b0;
			end
		endcase
	end

	assign snan_any  = class_a_q[`FPU_CLASS_SNAN] | class_b_q[`FPU_CLASS_SNAN];
	assign invalid_d = valid_op & (snan_any | (unordered & ordered_op));

	always_ff @(posedge clk) begin
		if (rst) begin
			done    <= 1'b0;
			flag    <= 1'b0;
			invalid <= 1'b0;
			class_a <= '0;
		end else begin
			done <= cmp_valid;
			if (cmp_valid) begin
				flag    <= flag_d;
				invalid <= invalid_d;
				class_a <= class_a_q;
			end
		end
	end

endmodule

// ==== hdl/fpu_cmp_top.sv ====
`timescale 1ns/100ps

module fpu_cmp_top import fpu_float_pkg::*, fpu_cmp_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      start,
	input  float32_t  opa,
	input  float32_t  opb,
	input  cmp_op_t   cmp_op,
	output logic      done,
	output logic      flag,
	output logic      invalid,
	output fp_class_t class_a
);

	logic      altb;
	logic      blta;
	logic      aeqb;
	logic      unordered;
	logic      cmp_valid;
	fp_class_t class_a_q;
	fp_class_t class_b_q;

	// ------------------------------------------------------------
	// Stage 1 runs the comparator and both classifiers side by side
	// ------------------------------------------------------------
	fpu_fcmp fcmp0 (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.opa       (opa),
		.opb       (opb),
		.altb      (altb),
		.blta      (blta),
		.aeqb      (aeqb),
		.unordered (unordered),
		.cmp_valid (cmp_valid)
	);

	fpu_class class_a0 (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.op       (opa),
		.op_class (class_a_q)
	);

	fpu_class class_b0 (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.op       (opb),
		.op_class (class_b_q)
	);

	// Stage 2.
	fpu_cmp_result result0 (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.cmp_op    (cmp_op),
		.altb      (altb),
		.blta      (blta),
		.aeqb      (aeqb),
		.unordered (unordered),
		.cmp_valid (cmp_valid),
		.class_a_q (class_a_q),
		.class_b_q (class_b_q),
		.done      (done),
		.flag      (flag),
		.invalid   (invalid),
		.class_a   (class_a)
	);

endmodule

// ==== hdl/fpu_fcmp.sv ====
`timescale 1ns/100ps
`include "fpu_cfg.svh"

module fpu_fcmp import fpu_float_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     start,
	input  float32_t opa,
	input  float32_t opb,
	output logic     altb,
	output logic     blta,
	output logic     aeqb,
	output logic     unordered,
	output logic     cmp_valid
);

	logic   sign_a;
	logic   sign_b;
	exp_t   exp_a;
	exp_t   exp_b;
	fract_t fract_a;
	fract_t fract_b;
	logic   exp_ff_a;
	logic   exp_ff_b;
	logic   fract_00_a;
	logic   fract_00_b;
	logic   nan_any;
	logic   inf_a;
	logic   inf_b;
	logic   all_zero;
	logic   exp_gt;
	logic   exp_lt;
	logic   fract_gt;
	logic   fract_lt;
	logic [2:0] ord_d;	// {altb, blta, aeqb} before the register.

	// ------------------------------------------------------------
	// Field split and special value detection
	// ------------------------------------------------------------
	assign sign_a  = opa[`FPU_SIGN_POS];
	assign sign_b  = opb[`FPU_SIGN_POS];
	assign exp_a   = opa[`FPU_EXP_MSB:`FPU_EXP_LSB];
	assign exp_b   = opb[`FPU_EXP_MSB:`FPU_EXP_LSB];
	assign fract_a = opa[`FPU_FRACT_W-1:0];
	assign fract_b = opb[`FPU_FRACT_W-1:0];

	assign exp_ff_a   = &exp_a;
	assign exp_ff_b   = &exp_b;
	assign fract_00_a = ~(|fract_a);
	assign fract_00_b = ~(|fract_b);

	assign nan_any  = (exp_ff_a & ~fract_00_a) | (exp_ff_b & ~fract_00_b);
	assign inf_a    = exp_ff_a & fract_00_a;
	assign inf_b    = exp_ff_b & fract_00_b;
	assign all_zero = ~(|exp_a) & fract_00_a & ~(|exp_b) & fract_00_b;	// Covers +0 against -0.

	assign exp_gt   = exp_a > exp_b;
	assign exp_lt   = exp_a < exp_b;
	assign fract_gt = fract_a > fract_b;
	assign fract_lt = fract_a < fract_b;

	// ------------------------------------------------------------
	// Priority decode where the first matching line wins
	// ------------------------------------------------------------
	always_comb begin
		casez ({nan_any, inf_a, inf_b, all_zero, sign_a, sign_b,
			exp_gt, exp_lt, fract_gt, fract_lt})
			10'b1_??_?_??_??_??: ord_d = 3'b000;	// Any NaN leaves the pair unordered.
			10'b0_11_?_00_??_??: ord_d = 3'b001;
			10'b0_11_?_11_??_??: ord_d = 3'b001;
			10'b0_11_?_10_??_??: ord_d = 3'b100;
			10'b0_11_?_01_??_??: ord_d = 3'b010;
			10'b0_10_?_0?_??_??: ord_d = 3'b010;	// Only a is infinite.
			10'b0_10_?_1?_??_??: ord_d = 3'b100;
			10'b0_01_?_?0_??_??: ord_d = 3'b100;	// Only b is infinite.
			10'b0_01_?_?1_??_??: ord_d = 3'b010;
			10'b0_00_1_??_??_??: ord_d = 3'b001;
			10'b0_00_0_10_??_??: ord_d = 3'b100;	// Signs differ.
			10'b0_00_0_01_??_??: ord_d = 3'b010;
			10'b0_00_0_00_10_??: ord_d = 3'b010;
			10'b0_00_0_00_01_??: ord_d = 3'b100;
			10'b0_00_0_11_10_??: ord_d = 3'b100;	// Negative pair reverses the magnitude order.
			10'b0_00_0_11_01_??: ord_d = 3'b010;
			10'b0_00_0_00_00_10: ord_d = 3'b010;
			10'b0_00_0_00_00_01: ord_d = 3'b100;
			10'b0_00_0_11_00_10: ord_d = 3'b100;
			10'b0_00_0_11_00_01: ord_d = 3'b010;
			default:             ord_d = 3'b001;	// Same sign, exponent and fraction.
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cmp_valid <= 1'b0;
		end else begin
			cmp_valid <= start;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			{altb, blta, aeqb} <= ord_d;
			unordered          <= nan_any;
		end
	end

endmodule

// ==== hdl/fpu_float_pkg.sv ====
`include "fpu_cfg.svh"

// Number format types for single precision words.
package fpu_float_pkg;

	// One complete binary32 word.
	typedef logic [`FPU_WORD_W-1:0] float32_t;

	// Biased exponent field.
	typedef logic [`FPU_EXP_W-1:0] exp_t;

	// Fraction field without the hidden bit.
	typedef logic [`FPU_FRACT_W-1:0] fract_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f fpu_cmp_top.f --top-module fpu_cmp_tb \
	-o fpu_cmp_sim > build.log 2>&1 || { cat build.log; echo "Verilator build error"; exit 1; }

./obj_dir/fpu_cmp_sim > sim.log 2>&1
cat sim.log

grep -qx "sim passed" sim.log && exit 0 || exit 1

// ==== verification/fpu_cmp_tb.sv ====
`timescale 1ns/100ps
`include "fpu_cfg.svh"

module fpu_cmp_tb import fpu_float_pkg::*, fpu_cmp_pkg::*; ();

	logic      clk;
	logic      rst;
	logic      start;
	float32_t  opa;
	float32_t  opb;
	cmp_op_t   cmp_op;
	logic      done;
	logic      flag;
	logic      invalid;
	fp_class_t class_a;
	int        checks;
	int        errors;

	fpu_cmp_top dut0 (
		.clk     (clk),
		.rst     (rst),
		.start   (start),
		.opa     (opa),
		.opb     (opb),
		.cmp_op  (cmp_op),
		.done    (done),
		.flag    (flag),
		.invalid (invalid),
		.class_a (class_a)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------
	function automatic fp_class_t class_of(input float32_t w);
		fp_class_t c;
		c = '0;
		if (w[30:23] == 8'hff && w[22:0] != 23'd0) begin
			c[w[22] ? `FPU_CLASS_QNAN : `FPU_CLASS_SNAN] = 1'b1;
		end else if (w[30:23] == 8'hff) begin
			c[w[31] ? `FPU_CLASS_NINF : `FPU_CLASS_PINF] = 1'b1;
		end else if (w[30:0] == 31'd0) begin
			c[w[31] ? `FPU_CLASS_NZERO : `FPU_CLASS_PZERO] = 1'b1;
		end else if (w[30:23] == 8'h00) begin
			c[w[31] ? `FPU_CLASS_NSUB : `FPU_CLASS_PSUB] = 1'b1;
		end else begin
			c[w[31] ? `FPU_CLASS_NNORM : `FPU_CLASS_PNORM] = 1'b1;
		end
		return c;
	endfunction

	// Sign and magnitude laid onto a signed integer line, so -0 meets +0.
	function automatic logic signed [31:0] order_key(input float32_t w);
		logic signed [31:0] mag;
		mag = {1'b0, w[30:0]};
		return w[31] ? -mag : mag;
	endfunction

	// Returns {flag, invalid, class of a}.
	function automatic logic [11:0] expect_result(input float32_t a, input float32_t b,
		input cmp_op_t op);
		fp_class_t ca;
		fp_class_t cb;
		logic      nan;
		logic      snan;
		logic      lt;
		logic      gt;
		logic      eq;
		logic      fl;
		logic      inv;
		ca   = class_of(a);
		cb   = class_of(b);
		snan = ca[`FPU_CLASS_SNAN] | cb[`FPU_CLASS_SNAN];
		nan  = snan | ca[`FPU_CLASS_QNAN] | cb[`FPU_CLASS_QNAN];
		lt   = !nan && (order_key(a) < order_key(b));
		gt   = !nan && (order_key(a) > order_key(b));
		eq   = !nan && (order_key(a) == order_key(b));
		case (op)
			`FPU_CMP_EQ: fl = eq;
			`FPU_CMP_NE: fl = !eq;
			`FPU_CMP_LT: fl = lt;
			`FPU_CMP_LE: fl = lt | eq;
			`FPU_CMP_GT: fl = gt;
			`FPU_CMP_GE: fl = gt | eq;
			default:     fl = 1'b0;
		endcase
		inv = (op <= `FPU_CMP_GE) && (snan || (nan && op >= `FPU_CMP_LT));
		return {fl, inv, ca};
	endfunction

	function automatic float32_t random_operand();
		logic [31:0] r;
		logic [31:0] v;
		r = $urandom();
		v = $urandom();
		case (r[31:29])
			3'd0:    return {r[28], 8'hff, 23'd0};
			3'd1:    return {r[28], 8'hff, 1'b1, r[21:0]};
			3'd2:    return {r[28], 8'hff, 1'b0, r[21:1], 1'b1};
			3'd3:    return {r[28], 8'd127, 20'd0, r[2:0]};	// Kept narrow so that equal pairs occur.
			3'd4:    return {r[28], 31'd0};
			default: return v;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [11:0] expected,
		input logic [11:0] actual);
		checks++;
		assert (expected == actual) else begin
			errors++;
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic run_op(input string name, input float32_t a, input float32_t b,
		input cmp_op_t op);
		int wait_cycles;
		@(posedge clk);
		start  <= 1'b1;
		opa    <= a;
		opb    <= b;
		cmp_op <= op;
		@(posedge clk);
		start <= 1'b0;
		wait_cycles = 0;
		@(negedge clk);
		while (!done && wait_cycles < 8) begin
			@(negedge clk);
			wait_cycles++;
		end
		if (!done) begin
			errors++;
			$display("Timeout in %s, the DUT never raised done", name);
		end else begin
			check_value(name, expect_result(a, b, op), {flag, invalid, class_a});
		end
	endtask

	task automatic sweep_ops(input string name, input float32_t a, input float32_t b);
		for (int k = 0; k < 8; k++) begin
			run_op($sformatf("%s op%0d", name, k), a, b, cmp_op_t'(k));
		end
	endtask

	// ------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------
	task automatic reset_state();
		@(negedge clk);
		check_value("reset done", 12'd0, {11'd0, done});
		check_value("reset outputs", 12'd0, {flag, invalid, class_a});
	endtask

	task automatic ordered_normals();
		sweep_ops("normal 1.0/2.0", 32'h3f800000, 32'h40000000);
		sweep_ops("normal 2.0/1.0", 32'h40000000, 32'h3f800000);
		sweep_ops("normal 1.5/1.25", 32'h3fc00000, 32'h3fa00000);
		sweep_ops("normal 1.5/1.5", 32'h3fc00000, 32'h3fc00000);
		sweep_ops("normal -1.5/1.25", 32'hbfc00000, 32'h3fa00000);
		sweep_ops("normal -2.0/-1.0", 32'hc0000000, 32'hbf800000);
		sweep_ops("normal -1.25/-1.5", 32'hbfa00000, 32'hbfc00000);
	endtask

	task automatic special_values();
		sweep_ops("+0/-0", 32'h00000000, 32'h80000000);
		sweep_ops("-inf/+inf", 32'hff800000, 32'h7f800000);
		sweep_ops("+inf/max", 32'h7f800000, 32'h7f7fffff);
		sweep_ops("-inf/-max", 32'hff800000, 32'hff7fffff);
		sweep_ops("sub/min normal", 32'h007fffff, 32'h00800000);
		sweep_ops("-sub/-0", 32'h80000001, 32'h80000000);
	endtask

	task automatic nan_operands();
		sweep_ops("qnan/1.0", 32'h7fc00000, 32'h3f800000);
		sweep_ops("1.0/-qnan", 32'h3f800000, 32'hffc00000);
		sweep_ops("snan/1.0", 32'h7f800001, 32'h3f800000);
		sweep_ops("1.0/-snan", 32'h3f800000, 32'hff800001);
		sweep_ops("qnan/snan", 32'h7fc00001, 32'h7fa00000);
	endtask

	task automatic class_reports();
		float32_t vals [10];
		vals = '{32'hff800000, 32'hbf800000, 32'h80000001, 32'h80000000, 32'h00000000,
			32'h00000001, 32'h3f800000, 32'h7f800000, 32'h7f800001, 32'h7fc00000};
		for (int i = 0; i < 10; i++) begin
			run_op($sformatf("class %0d", i), vals[i], 32'h3f800000, `FPU_CMP_EQ);
			check_value($sformatf("class bit %0d", i), {2'b00, 10'd1 << i}, {2'b00, class_a});
		end
	endtask

	task automatic back_to_back(input int count);
		logic [11:0] exp_q [$];
		int          issue_q [$];
		float32_t    a;
		float32_t    b;
		cmp_op_t     op;
		int          issue;
		for (int c = 0; c < count + 4; c++) begin
			@(posedge clk);
			if (c < count) begin
				a  = random_operand();
				b  = random_operand();
				op = cmp_op_t'($urandom_range(0, 7));
				start  <= 1'b1;
				opa    <= a;
				opb    <= b;
				cmp_op <= op;
				exp_q.push_back(expect_result(a, b, op));
				issue_q.push_back(c);
			end else begin
				start <= 1'b0;
			end
			@(negedge clk);
			if (done && exp_q.size() == 0) begin
				errors++;
				$display("The DUT raised done with no operation in flight");
			end else if (done) begin
				issue = issue_q.pop_front();
				check_value("back to back latency", 12'd2, 12'(c - issue));
				check_value("back to back result", exp_q.pop_front(), {flag, invalid, class_a});
			end
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d back to back operations never raised done", exp_q.size());
		end
	endtask

	initial begin
		void'($urandom(32'h72741435));
		checks = 0;
		errors = 0;
		rst    = 1'b1;
		start  = 1'b0;
		opa    = '0;
		opb    = '0;
		cmp_op = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		reset_state();
		ordered_normals();
		special_values();
		nan_operands();
		class_reports();
		back_to_back(40);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
